/* Bender.yml */
package:
  name: vld_engine

export_include_dirs:
  - logic

sources:
  - logic/vld_instr_pkg.sv
  - logic/vld_bus_pkg.sv
  - logic/vld_req_issuer.sv
  - logic/vld_resp_collector.sv
  - logic/vld_wb_merge.sv
  - logic/vld_top.sv
  - target: test
    files:
      - test/vld_properties.sv
      - test/vld_tb.sv

/* logic/vld_bus_pkg.sv */
// ======================================
// Bus side types: tickets, memory request and
// response, row announcements, writeback
// ======================================
`include "vld_defs.svh"

package vld_bus_pkg;

    import vld_instr_pkg::*;

    typedef logic [$clog2(`VLD_LANES)-1:0] lane_idx_t;

    // Identifies one outstanding element
    typedef struct packed {
        logic      row;   // Row buffer
        lane_idx_t lane;  // Lane inside the row
    } ticket_t;

    typedef struct packed {
        logic [`VLD_ADDR_W-1:0] addr;
        ticket_t                ticket;
    } mem_req_t;

    typedef struct packed {
        ticket_t                ticket;
        logic [`VLD_DATA_W-1:0] data;
    } mem_resp_t;

    // Sent once when a row starts collecting a new register
    typedef struct packed {
        logic                  row;
        logic [`VLD_LANES-1:0] mask;  // Lanes that will be requested
        vreg_idx_t             dst;
    } row_open_t;

    // One full vector register
    typedef logic [`VLD_LANES-1:0][`VLD_DATA_W-1:0] lane_data_t;

    typedef struct packed {
        vreg_idx_t             dst;
        logic [`VLD_LANES-1:0] en;    // Per lane write enable
        lane_data_t            data;
    } vld_wb_t;

endpackage

/* logic/vld_defs.svh */
// ======================================
// Sizing macros of the vector load engine
// ======================================
`ifndef VLD_DEFS_SVH
`define VLD_DEFS_SVH

// Vector register file geometry
`define VLD_LANES     8
`define VLD_VREGS     32

// Element and address widths in bits
`define VLD_DATA_W    32
`define VLD_ADDR_W    32

// Most destination registers per instruction
`define VLD_MAX_GROUP 4

`endif

/* logic/vld_instr_pkg.sv */
// ======================================
// Instruction side types: addressing mode,
// register number, vector length, instruction
// ======================================
`include "vld_defs.svh"

package vld_instr_pkg;

    // Addressing modes of a vector load
    typedef enum logic [1:0] {
        OP_UNIT_STRIDED = 2'd0,
        OP_STRIDED      = 2'd1,
        OP_INDEXED      = 2'd2
    } mem_op_e;

    typedef logic [$clog2(`VLD_VREGS)-1:0] vreg_idx_t;

    // 0 .. lanes * group elements
    typedef logic [$clog2(`VLD_LANES * `VLD_MAX_GROUP):0] vlen_t;

    // Decoded vector load
    typedef struct packed {
        mem_op_e                op;       // Addressing mode
        vreg_idx_t              dst;      // First destination register
        vreg_idx_t              idx_src;  // First index register, indexed mode only
        vlen_t                  vl;       // Elements to load
        logic [`VLD_ADDR_W-1:0] base;     // Byte address of element 0
        logic [`VLD_ADDR_W-1:0] stride;   // Byte step, strided mode only
    } vld_instr_t;

endpackage

/* logic/vld_req_issuer.sv */
// ======================================
// Instruction capture, register expansion
// and memory request issue
// ======================================
`timescale 1ns/1ps
`include "vld_defs.svh"

module vld_req_issuer (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      instr_valid_i,
    input  vld_instr_pkg::vld_instr_t instr_i,
    output logic                      instr_ready_o,
    output logic                      busy_o,
    input  logic                      grant_i,
    output logic                      mem_req_valid_o,
    output vld_bus_pkg::mem_req_t     mem_req_o,
    output vld_instr_pkg::vreg_idx_t  rf_rd_addr_o,
    input  vld_bus_pkg::lane_data_t   rf_rd_data_i,
    input  logic [1:0]                row_active_i,
    output logic                      row_open_valid_o,
    output vld_bus_pkg::row_open_t    row_open_o
);
    import vld_instr_pkg::*;
    import vld_bus_pkg::*;

    localparam int LANE_W  = $clog2(`VLD_LANES);
    localparam int GROUP_W = $clog2(`VLD_MAX_GROUP);

    mem_op_e                    op_r;
    vlen_t                      vl_r;
    logic [`VLD_ADDR_W-1:0]     base_r;
    logic [`VLD_ADDR_W-1:0]     stride_r;
    logic [`VLD_ADDR_W-1:0]     addr_r;      // Running address, unit and strided
    logic [`VLD_ADDR_W-1:0]     cur_addr;
    vreg_idx_t                  dst_r;
    vreg_idx_t                  idx_r;
    logic [GROUP_W-1:0]         loop_r;      // Register of the group being issued
    logic [GROUP_W:0]           loop_next;
    lane_idx_t                  ptr_r;
    logic                       row_r;
    logic [1:0][`VLD_LANES-1:0] pend_r;      // Lanes not yet requested, per row
    logic [`VLD_LANES-1:0]      first_mask;
    logic [`VLD_LANES-1:0]      loop_mask;
    vlen_t                      elems_opened;
    vlen_t                      remaining;
    logic                       vl_reached;
    logic                       group_reached;
    logic                       expand_done;
    logic                       start_instr;
    logic                       start_loop;
    logic                       req_fire;
    logic                       next_row;

    // Low n lanes set, all of them once n reaches a full register
    function automatic logic [`VLD_LANES-1:0] lane_mask(input vlen_t n);
        logic [`VLD_LANES-1:0] m;
        if (n >= vlen_t'(`VLD_LANES)) begin
            m = '1;
        end else begin
            m = ~({`VLD_LANES{1'b1}} << n);
        end
        return m;
    endfunction

    // ======================================
    // Expansion control
    // ======================================
    assign loop_next     = {1'b0, loop_r} + 1'b1;
    assign elems_opened  = vlen_t'(loop_next) << LANE_W;  // Elements covered so far
    assign remaining     = vl_r - elems_opened;
    assign vl_reached    = elems_opened >= vl_r;
    assign group_reached = loop_r == GROUP_W'(`VLD_MAX_GROUP - 1);
    assign expand_done   = vl_reached | group_reached;

    assign first_mask = lane_mask(instr_i.vl);
    assign loop_mask  = lane_mask(remaining);

    // Idle once nothing is left to request, collect or expand
    assign instr_ready_o = ~|pend_r & ~|row_active_i & expand_done;
    assign busy_o        = ~instr_ready_o;
    assign start_instr   = instr_valid_i & instr_ready_o;

    // Move to the other row once this one is fully requested and the other is free
    assign next_row   = ~row_r;
    assign start_loop = ~|pend_r[row_r] & ~expand_done & ~row_active_i[next_row];

    assign row_open_valid_o = start_instr | start_loop;
    assign row_open_o.row   = start_instr ? 1'b0 : next_row;
    assign row_open_o.mask  = start_instr ? first_mask : loop_mask;
    assign row_open_o.dst   = start_instr ? instr_i.dst : dst_r + 1'b1;

    // ======================================
    // Address generation
    // ======================================
    assign rf_rd_addr_o = idx_r;

    always_comb begin
        case (op_r)
            OP_INDEXED: cur_addr = base_r + rf_rd_data_i[ptr_r];  // Base plus lane offset
            default:    cur_addr = addr_r;
        endcase
    end

    assign mem_req_valid_o       = pend_r[row_r][ptr_r];
    assign req_fire              = mem_req_valid_o & grant_i;
    assign mem_req_o.addr        = cur_addr;
    assign mem_req_o.ticket.row  = row_r;
    assign mem_req_o.ticket.lane = ptr_r;

    always_ff @(posedge clk_i) begin
        if (start_instr) begin
            base_r   <= instr_i.base;
            stride_r <= instr_i.stride;
            addr_r   <= instr_i.base;
        end else if (req_fire) begin
            if (op_r == OP_STRIDED) begin
                addr_r <= addr_r + stride_r;
            end else begin
                addr_r <= addr_r + `VLD_ADDR_W'(`VLD_DATA_W / 8);  // Next 32-bit word
            end
        end
    end

    // ======================================
    // Loop, pointer and pending state
    // ======================================
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            op_r   <= OP_UNIT_STRIDED;
            vl_r   <= '0;
            loop_r <= '0;
            ptr_r  <= '0;
            row_r  <= 1'b0;
            dst_r  <= '0;
            idx_r  <= '0;
        end else if (start_instr) begin
            op_r   <= instr_i.op;
            vl_r   <= instr_i.vl;
            loop_r <= '0;
            ptr_r  <= '0;
            row_r  <= 1'b0;
            dst_r  <= instr_i.dst;
            idx_r  <= instr_i.idx_src;
        end else if (start_loop) begin
            loop_r <= loop_next[GROUP_W-1:0];
            ptr_r  <= '0;
            row_r  <= next_row;
            dst_r  <= dst_r + 1'b1;
            idx_r  <= idx_r + 1'b1;   // Index register follows the group
        end else if (req_fire) begin
            ptr_r  <= ptr_r + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pend_r <= '0;
        end else if (start_instr) begin
            pend_r[0] <= first_mask;
            pend_r[1] <= '0;
        end else if (start_loop) begin
            pend_r[next_row] <= loop_mask;
        end else if (req_fire) begin
            pend_r[row_r][ptr_r] <= 1'b0;
        end
    end

endmodule

/* logic/vld_resp_collector.sv */
// ======================================
// Row buffers of returned load data and
// their served masks
// ======================================
`timescale 1ns/1ps
`include "vld_defs.svh"

module vld_resp_collector (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  logic                           mem_resp_valid_i,
    input  vld_bus_pkg::mem_resp_t         mem_resp_i,
    input  logic                           row_open_valid_i,
    input  vld_bus_pkg::row_open_t         row_open_i,
    output logic [1:0][`VLD_LANES-1:0]     served_o,
    output vld_bus_pkg::lane_data_t [1:0]  row_data_o
);
    import vld_bus_pkg::*;

    logic      resp_row;
    lane_idx_t resp_lane;

    // Ticket says where the element goes
    assign resp_row  = mem_resp_i.ticket.row;
    assign resp_lane = mem_resp_i.ticket.lane;

    // ======================================
    // Served masks
    // ======================================
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            served_o <= '0;
        end else begin
            for (int r = 0; r < 2; r++) begin
                if (row_open_valid_i && row_open_i.row == 1'(r)) begin
                    served_o[r] <= '0;                    // Fresh register in this row
                end else if (mem_resp_valid_i && resp_row == 1'(r)) begin
                    served_o[r][resp_lane] <= 1'b1;
                end
            end
        end
    end

    // ======================================
    // Data buffers
    // ======================================
    always_ff @(posedge clk_i) begin
        if (mem_resp_valid_i) begin
            row_data_o[resp_row][resp_lane] <= mem_resp_i.data;
        end
    end

endmodule

/* logic/vld_top.sv */
// ======================================
// Vector load engine top level
// ======================================
`timescale 1ns/1ps
`include "vld_defs.svh"

module vld_top (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    // Instruction in
    input  logic                      instr_valid_i,
    input  vld_instr_pkg::vld_instr_t instr_i,
    output logic                      instr_ready_o,
    // Memory request and response
    output logic                      mem_req_valid_o,
    output vld_bus_pkg::mem_req_t     mem_req_o,
    input  logic                      grant_i,
    input  logic                      mem_resp_valid_i,
    input  vld_bus_pkg::mem_resp_t    mem_resp_i,
    // Register file
    output vld_instr_pkg::vreg_idx_t  rf_rd_addr_o,
    input  vld_bus_pkg::lane_data_t   rf_rd_data_i,
    output logic                      wb_valid_o,
    output vld_bus_pkg::vld_wb_t      wb_o,
    output logic                      busy_o
);
    import vld_bus_pkg::*;

    logic                       row_open_valid;
    row_open_t                  row_open;
    logic [1:0][`VLD_LANES-1:0] served;
    lane_data_t [1:0]           row_data;
    logic [1:0]                 row_active;

    // ======================================
    // Request side
    // ======================================
    vld_req_issuer vld_req_issuer_inst (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .instr_valid_i    (instr_valid_i),
        .instr_i          (instr_i),
        .instr_ready_o    (instr_ready_o),
        .busy_o           (busy_o),
        .grant_i          (grant_i),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_o        (mem_req_o),
        .rf_rd_addr_o     (rf_rd_addr_o),
        .rf_rd_data_i     (rf_rd_data_i),
        .row_active_i     (row_active),
        .row_open_valid_o (row_open_valid),
        .row_open_o       (row_open)
    );

    // ======================================
    // Response side
    // ======================================
    vld_resp_collector vld_resp_collector_inst (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_i       (mem_resp_i),
        .row_open_valid_i (row_open_valid),
        .row_open_i       (row_open),
        .served_o         (served),
        .row_data_o       (row_data)
    );

    vld_wb_merge vld_wb_merge_inst (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .row_open_valid_i (row_open_valid),
        .row_open_i       (row_open),
        .served_i         (served),
        .row_data_i       (row_data),
        .row_active_o     (row_active),   // Back to the issuer for row reuse
        .wb_valid_o       (wb_valid_o),
        .wb_o             (wb_o)
    );

endmodule

/* logic/vld_wb_merge.sv */
// ======================================
// Active row tracking, completion check and
// register file writeback
// ======================================
`timescale 1ns/1ps
`include "vld_defs.svh"

module vld_wb_merge (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic                          row_open_valid_i,
    input  vld_bus_pkg::row_open_t        row_open_i,
    input  logic [1:0][`VLD_LANES-1:0]    served_i,
    input  vld_bus_pkg::lane_data_t [1:0] row_data_i,
    output logic [1:0]                    row_active_o,
    output logic                          wb_valid_o,
    output vld_bus_pkg::vld_wb_t          wb_o
);
    import vld_instr_pkg::*;

    logic [1:0][`VLD_LANES-1:0] active_r;   // Lanes expected per row
    vreg_idx_t [1:0]            dst_r;
    logic [1:0]                 row_done;
    logic                       wb_row;

    // ======================================
    // Completion and writeback select
    // ======================================
    always_comb begin
        for (int r = 0; r < 2; r++) begin
            row_done[r]     = |active_r[r] && (served_i[r] == active_r[r]);
            row_active_o[r] = |active_r[r];
        end
    end

    assign wb_valid_o = |row_done;
    assign wb_row     = ~row_done[0];    // Row 0 wins a tie

    assign wb_o.dst  = dst_r[wb_row];
    assign wb_o.en   = served_i[wb_row];
    assign wb_o.data = row_data_i[wb_row];

    // ======================================
    // Row state
    // ======================================
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            active_r <= '0;
        end else begin
            for (int r = 0; r < 2; r++) begin
                if (wb_valid_o && wb_row == 1'(r)) begin
                    active_r[r] <= '0;               // Row free again
                end else if (row_open_valid_i && row_open_i.row == 1'(r)) begin
                    active_r[r] <= row_open_i.mask;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (row_open_valid_i) begin
            dst_r[row_open_i.row] <= row_open_i.dst;
        end
    end

endmodule

/* test/vld_properties.sv */
// ======================================
// Concurrent checks on the request handshake,
// status outputs and writeback enables
// ======================================
`timescale 1ns/1ps

module vld_properties (
    input logic                  clk_i,
    input logic                  rstn_i,
    input logic                  instr_ready_o,
    input logic                  busy_o,
    input logic                  mem_req_valid_o,
    input vld_bus_pkg::mem_req_t mem_req_o,
    input logic                  grant_i,
    input logic                  wb_valid_o,
    input vld_bus_pkg::vld_wb_t  wb_o
);
    int unsigned fail_count = 0;

    // Request must wait unchanged for its grant
    req_held_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_req_valid_o && !grant_i |=> mem_req_valid_o && $stable(mem_req_o))
        else begin
            $error("Memory request dropped or changed while grant_i was low");
            fail_count++;
        end

    // Engine reports busy while it has traffic
    ready_busy_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (mem_req_valid_o || wb_valid_o) |-> busy_o && !instr_ready_o)
        else begin
            $error("instr_ready_o high or busy_o low during a request or writeback");
            fail_count++;
        end

    // A writeback always carries at least one lane
    wb_enable_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wb_valid_o |-> |wb_o.en)
        else begin
            $error("Writeback with an all-zero lane enable");
            fail_count++;
        end

endmodule

bind vld_top vld_properties vld_properties_inst (.*);

/* test/vld_tb.sv */
// ======================================
// Testbench of the vector load engine with
// memory and register file models
// ======================================
`timescale 1ns/1ps
`include "vld_defs.svh"

module vld_tb;
    import vld_instr_pkg::*;
    import vld_bus_pkg::*;

    localparam int NUM_LOADS      = 5;
    localparam int TIMEOUT_CYCLES = NUM_LOADS * 200 + 20;  // Reset and drain margin

    logic       clk_i;
    logic       rstn_i;
    logic       instr_valid_i;
    vld_instr_t instr_i;
    logic       instr_ready_o;
    logic       mem_req_valid_o;
    mem_req_t   mem_req_o;
    logic       grant_i;
    logic       mem_resp_valid_i;
    mem_resp_t  mem_resp_i;
    vreg_idx_t  rf_rd_addr_o;
    lane_data_t rf_rd_data_i;
    logic       wb_valid_o;
    vld_wb_t    wb_o;
    logic       busy_o;

    logic [31:0] rng_state = 32'h8293;
    int          grant_pct = 75;      // Chance of a grant per cycle
    int unsigned cycles = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    int          wb_checked = 0;
    int          req_checked = 0;
    int          req_count = 0;       // Requests of the current load
    logic        ready_due = 1'b0;
    vld_instr_t  cur_instr;
    vld_wb_t     exp_q[$];            // Writebacks still expected
    mem_req_t    sent_q[$];           // Granted requests awaiting a response

    vld_top vld_top_inst (.*);

    always #5 clk_i = ~clk_i;

    // ======================================
    // Random numbers and reference model
    // ======================================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] rand_next();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Register r, lane j holds byte offset 4*(r+j)
    function automatic logic [31:0] rf_offset(input vreg_idx_t r, input int j);
        return 32'(4 * (int'(r) + j));
    endfunction

    function automatic logic [31:0] elem_addr(input vld_instr_t ins, input int e);
        vreg_idx_t r;
        r = vreg_idx_t'(ins.idx_src + e / `VLD_LANES);
        case (ins.op)
            OP_STRIDED: return ins.base + ins.stride * 32'(e);
            OP_INDEXED: return ins.base + rf_offset(r, e % `VLD_LANES);
            default:    return ins.base + 32'(4 * e);
        endcase
    endfunction

    function automatic int reg_count(input vlen_t vl);
        int n;
        n = (int'(vl) + `VLD_LANES - 1) / `VLD_LANES;
        return (n > `VLD_MAX_GROUP) ? `VLD_MAX_GROUP : n;
    endfunction

    // Expected writeback of register g of a load
    function automatic vld_wb_t ref_wb(input vld_instr_t ins, input int g);
        vld_wb_t w;
        int      e;
        w     = '0;
        w.dst = vreg_idx_t'(ins.dst + g);
        for (int j = 0; j < `VLD_LANES; j++) begin
            e = g * `VLD_LANES + j;
            if (e < int'(ins.vl)) begin
                w.en[j]   = 1'b1;
                w.data[j] = xorshift32(elem_addr(ins, e));
            end
        end
        return w;
    endfunction

    function automatic vld_instr_t make_instr(input mem_op_e op, input int dst, input int idx,
                                              input int vl, input logic [31:0] base,
                                              input logic [31:0] stride);
        vld_instr_t ins;
        ins.op      = op;
        ins.dst     = vreg_idx_t'(dst);
        ins.idx_src = vreg_idx_t'(idx);
        ins.vl      = vlen_t'(vl);
        ins.base    = base;
        ins.stride  = stride;
        return ins;
    endfunction

    // ======================================
    // Compare tasks
    // ======================================
    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic compare_req(input mem_req_t got, input mem_req_t exp);
        req_checked++;
        if (got.addr !== exp.addr) begin
            value_errors++;
            $display("** Error: mem_req_o.addr got 0x%08h expected 0x%08h", got.addr, exp.addr);
        end
        if (got.ticket !== exp.ticket) begin
            value_errors++;
            $display("** Error: mem_req_o.ticket got 0x%0h expected 0x%0h",
                     got.ticket, exp.ticket);
        end
    endtask

    task automatic compare_wb(input vld_wb_t got, input vld_wb_t exp);
        wb_checked++;
        if (got.en !== exp.en) begin
            value_errors++;
            $display("** Error: wb_o.en (v%0d) got 0x%02h expected 0x%02h",
                     exp.dst, got.en, exp.en);
        end
        for (int j = 0; j < `VLD_LANES; j++) begin
            if (exp.en[j] && got.data[j] !== exp.data[j]) begin
                value_errors++;
                $display("** Error: wb_o.data[%0d] (v%0d) got 0x%08h expected 0x%08h",
                         j, exp.dst, got.data[j], exp.data[j]);
            end
        end
    endtask

    // ======================================
    // Memory and register file models
    // ======================================
    always_comb begin
        for (int j = 0; j < `VLD_LANES; j++) begin
            rf_rd_data_i[j] = rf_offset(rf_rd_addr_o, j);
        end
    end

    // Random grants, responses picked from any outstanding ticket
    always @(negedge clk_i) begin : memory_model
        int       k;
        mem_req_t r;
        grant_i          = rstn_i && ((rand_next() % 100) < grant_pct);
        mem_resp_valid_i = 1'b0;
        if (rstn_i && sent_q.size() != 0 && (rand_next() % 4) != 0) begin
            k = int'(rand_next() % sent_q.size());
            r = sent_q[k];
            sent_q.delete(k);
            mem_resp_i.ticket = r.ticket;
            mem_resp_i.data   = xorshift32(r.addr);
            mem_resp_valid_i  = 1'b1;
        end
    end

    // ======================================
    // Comparison process
    // ======================================
    always @(posedge clk_i) begin : monitor
        int       found;
        mem_req_t exp_req;
        if (rstn_i) begin
            if (ready_due && !instr_ready_o) begin
                other_errors++;
                $display("instr_ready_o did not rise the cycle after the last writeback");
            end
            ready_due = 1'b0;
            if (instr_ready_o && exp_q.size() != 0) begin
                other_errors++;
                $display("instr_ready_o high while %0d writebacks are outstanding",
                         exp_q.size());
            end
            if (instr_valid_i && instr_ready_o) begin
                cur_instr = instr_i;
                req_count = 0;
                for (int g = 0; g < reg_count(instr_i.vl); g++) begin
                    exp_q.push_back(ref_wb(instr_i, g));
                end
            end
            if (mem_req_valid_o && grant_i) begin
                exp_req.addr        = elem_addr(cur_instr, req_count);
                exp_req.ticket.row  = 1'((req_count / `VLD_LANES) % 2);   // Rows alternate
                exp_req.ticket.lane = lane_idx_t'(req_count % `VLD_LANES);
                compare_req(mem_req_o, exp_req);
                sent_q.push_back(mem_req_o);
                req_count++;
            end
            if (wb_valid_o) begin
                found = -1;
                foreach (exp_q[i]) begin
                    if (found < 0 && exp_q[i].dst == wb_o.dst) begin
                        found = i;
                    end
                end
                if (found < 0) begin
                    other_errors++;
                    $display("Unexpected or duplicate writeback to v%0d", wb_o.dst);
                end else begin
                    compare_wb(wb_o, exp_q[found]);
                    exp_q.delete(found);
                    ready_due = (exp_q.size() == 0);
                end
            end
        end
    end

    always @(posedge clk_i) begin : watchdog
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout: engine still busy after %0d cycles, %0d errors so far",
                     cycles, value_errors + other_errors);
            $display("Simulation failed");
            $finish;
        end
    end

    // ======================================
    // Stimulus
    // ======================================
    task automatic run_load(input vld_instr_t ins, input int pct);
        @(posedge clk_i);
        grant_pct = pct;
        @(negedge clk_i);
        instr_valid_i = 1'b1;
        instr_i       = ins;
        do @(posedge clk_i); while (!instr_ready_o);   // Accepted on this edge
        @(negedge clk_i);
        instr_valid_i = 1'b0;
        instr_i       = '0;
        while (!instr_ready_o) @(negedge clk_i);
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("Load to v%0d ended with %0d writebacks missing", ins.dst, exp_q.size());
            exp_q.delete();
        end
        if (req_count != int'(ins.vl)) begin
            other_errors++;
            $display("Load to v%0d sent %0d requests instead of %0d",
                     ins.dst, req_count, ins.vl);
        end
    endtask

    initial begin
        clk_i            = 1'b0;
        rstn_i           = 1'b0;
        instr_valid_i    = 1'b0;
        instr_i          = '0;
        grant_i          = 1'b0;
        mem_resp_valid_i = 1'b0;
        mem_resp_i       = '0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;
        @(negedge clk_i);

        // Idle state after reset
        compare_bit("instr_ready_o", instr_ready_o, 1'b1);
        compare_bit("mem_req_valid_o", mem_req_valid_o, 1'b0);
        compare_bit("wb_valid_o", wb_valid_o, 1'b0);
        compare_bit("busy_o", busy_o, 1'b0);

        run_load(make_instr(OP_UNIT_STRIDED, 4, 0, 5, 32'h0000_1000, 32'h0), 75);
        run_load(make_instr(OP_STRIDED, 8, 0, 20, 32'h0000_2000, 32'h24), 40);  // Grant stalls
        run_load(make_instr(OP_INDEXED, 12, 20, 12, 32'h0000_4000, 32'h0), 75);
        run_load(make_instr(OP_UNIT_STRIDED, 16, 0, 32, 32'h0000_8000, 32'h0), 95);
        run_load(make_instr(OP_INDEXED, 24, 3, 32, 32'h0001_0000, 32'h0), 60);
        repeat (3) @(negedge clk_i);

        $display("Checked %0d writebacks, %0d requests: %0d errors, %0d assertion failures",
                 wb_checked, req_checked, value_errors + other_errors,
                 vld_top_inst.vld_properties_inst.fail_count);
        if (value_errors + other_errors + vld_top_inst.vld_properties_inst.fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+logic
logic/vld_instr_pkg.sv
logic/vld_bus_pkg.sv
logic/vld_req_issuer.sv
logic/vld_resp_collector.sv
logic/vld_wb_merge.sv
logic/vld_top.sv
test/vld_properties.sv
test/vld_tb.sv
